//--- filelist.f
rtl/vmode_pkg.sv
rtl/dual_port_ram.sv
rtl/cpu_port_decoder.sv
rtl/line_fetcher.sv
rtl/pixel_lookup.sv
rtl/vmode_chunky.sv
sim/vram_model.sv
sim/tb_vmode_chunky.sv

//--- rtl/cpu_port_decoder.sv
`timescale 1ns/1ps

module cpu_port_decoder (
	input  logic                i_clock,
	input  logic                i_rst_n,

	// CPU
	input  logic                i_cpu_request,
	input  vmode_pkg::cpu_req_t i_cpu,
	output logic [31:0]         o_cpu_rdata,
	output logic                o_cpu_ready,

	// Video memory port A
	output vmode_pkg::mem_req_t o_vram_pa,
	input  vmode_pkg::mem_rsp_t i_vram_pa,

	// Palette write port
	output logic                o_pal_wr_en,
	output logic [7:0]          o_pal_wr_addr,
	output logic [23:0]         o_pal_wr_data,

	output logic [31:0]         o_vram_offset
);

	import vmode_pkg::*;

	cpu_region_t region;
	logic busy;
	logic accept;
	logic done;
	logic [31:0] cpu_offset;
	logic [31:0] pal_offset;
	logic pa_request;
	logic pa_rw;
	logic [31:0] pa_address;
	logic [31:0] pa_wdata;

	always_comb begin
		if (i_cpu.address < PALETTE_BASE) begin
			region = REGION_VRAM;
		end else if (i_cpu.address < CTRL_BASE) begin
			region = REGION_PALETTE;
		end else begin
			region = REGION_CTRL;
		end
	end

	// No new access while one is open or its ready is still out
	assign accept = i_cpu_request && !busy && !o_cpu_ready;
	assign done = busy && i_vram_pa.ready;
	assign pal_offset = i_cpu.address - PALETTE_BASE;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			busy <= 1'b0;
			pa_request <= 1'b0;
			o_cpu_ready <= 1'b0;
			o_pal_wr_en <= 1'b0;
			cpu_offset <= 32'h0;
			o_vram_offset <= 32'h0;
		end else begin
			o_cpu_ready <= 1'b0;
			o_pal_wr_en <= 1'b0;
			if (done) begin
				busy <= 1'b0;
				pa_request <= 1'b0;
				o_cpu_ready <= 1'b1;
			end else if (accept) begin
				case (region)
					REGION_VRAM: begin
						busy <= 1'b1;
						pa_request <= 1'b1;
					end
					REGION_PALETTE: begin
						o_pal_wr_en <= i_cpu.rw;
						o_cpu_ready <= 1'b1;
					end
					default: begin
						if (i_cpu.rw && i_cpu.address[3:0] == REG_VRAM_OFFSET) begin
							o_vram_offset <= i_cpu.wdata;
						end
						if (i_cpu.rw && i_cpu.address[3:0] == REG_CPU_OFFSET) begin
							cpu_offset <= i_cpu.wdata;
						end
						o_cpu_ready <= 1'b1;
					end
				endcase
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept) begin
			pa_rw <= i_cpu.rw;
			pa_address <= cpu_offset + i_cpu.address;
			pa_wdata <= i_cpu.wdata;
			// Entries are four bytes apart
			o_pal_wr_addr <= pal_offset[9:2];
			o_pal_wr_data <= i_cpu.wdata[23:0];
		end
		// Palette and control reads return zero
		if (done) begin
			o_cpu_rdata <= i_vram_pa.rdata;
		end else if (accept) begin
			o_cpu_rdata <= 32'h0;
		end
	end

	assign o_vram_pa = '{request: pa_request, rw: pa_rw, address: pa_address, wdata: pa_wdata};

endmodule

//--- rtl/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram #(
	parameter int WIDTH = 32,
	parameter int SIZE = 256
) (
	input  logic                    i_clock,

	// Write port
	input  logic                    i_wr_en,
	input  logic [$clog2(SIZE)-1:0] i_wr_addr,
	input  logic [WIDTH-1:0]        i_wr_data,

	// Read port, one cycle latency
	input  logic [$clog2(SIZE)-1:0] i_rd_addr,
	output logic [WIDTH-1:0]        o_rd_data
);

	logic [WIDTH-1:0] mem [SIZE];

	always_ff @(posedge i_clock) begin
		if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_data;
		end
	end

	// Registered read, old data on a same-address write
	always_ff @(posedge i_clock) begin
		o_rd_data <= mem[i_rd_addr];
	end

endmodule

//--- rtl/line_fetcher.sv
`timescale 1ns/1ps

module line_fetcher #(
	parameter int PPITCH = 320
) (
	input  logic                            i_clock,
	input  logic                            i_rst_n,

	input  vmode_pkg::video_in_t            i_video,
	input  logic [31:0]                     i_vram_offset,

	// Video memory port B, read only
	output vmode_pkg::mem_req_t             o_vram_pb,
	input  vmode_pkg::mem_rsp_t             i_vram_pb,

	// Line buffer write port
	output logic                            o_line_wr_en,
	output logic [$clog2(PPITCH/4)-1:0]     o_line_wr_addr,
	output logic [31:0]                     o_line_wr_data
);

	import vmode_pkg::*;

	localparam int WORDS = PPITCH / 4;
	localparam int AW = $clog2(WORDS);

	fetch_state_t state;
	logic [1:0] hs_sync;
	logic [1:0] vs_sync;
	logic hs_prev;
	logic vs_prev;
	logic start;
	logic start_fetch;
	logic word_done;
	logic next_word;
	logic [AW-1:0] count;
	logic [31:0] line_start;
	logic pb_request;
	logic [31:0] pb_address;

	// ======================================================================
	// Sync inputs and hsync edge
	// ======================================================================

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			hs_sync <= 2'b00;
			vs_sync <= 2'b00;
			hs_prev <= 1'b0;
			vs_prev <= 1'b0;
		end else begin
			hs_sync <= {hs_sync[0], i_video.hsync};
			vs_sync <= {vs_sync[0], i_video.vsync};
			hs_prev <= hs_sync[1];
			vs_prev <= vs_sync[1];
		end
	end

	assign start = hs_sync[1] && !hs_prev && !vs_prev;
	assign line_start = i_vram_offset + 32'(i_video.pos_y) * 32'(PPITCH);

	// ======================================================================
	// Fetch FSM
	// ======================================================================

	// Edges that arrive mid-fetch are dropped
	assign start_fetch = (state == FETCH_IDLE) && start;
	assign word_done = (state == FETCH_WAIT_READY) && i_vram_pb.ready;
	assign next_word = (state == FETCH_WAIT_RELEASE) && !i_vram_pb.ready;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= FETCH_IDLE;
			pb_request <= 1'b0;
			o_line_wr_en <= 1'b0;
			count <= '0;
		end else begin
			o_line_wr_en <= 1'b0;
			case (state)
				FETCH_IDLE: begin
					if (start_fetch) begin
						count <= '0;
						pb_request <= 1'b1;
						state <= FETCH_WAIT_READY;
					end
				end
				FETCH_WAIT_READY: begin
					if (word_done) begin
						pb_request <= 1'b0;
						o_line_wr_en <= 1'b1;
						count <= count + 1'b1;
						if (count == AW'(WORDS - 1)) begin
							state <= FETCH_IDLE;
						end else begin
							state <= FETCH_WAIT_RELEASE;
						end
					end
				end
				FETCH_WAIT_RELEASE: begin
					// Memory must drop ready before the next request
					if (next_word) begin
						pb_request <= 1'b1;
						state <= FETCH_WAIT_READY;
					end
				end
				default: begin
					pb_request <= 1'b0;
					state <= FETCH_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (start_fetch) begin
			pb_address <= line_start;
		end else if (next_word) begin
			pb_address <= pb_address + 32'd4;
		end
		if (word_done) begin
			o_line_wr_addr <= count;
			o_line_wr_data <= i_vram_pb.rdata;
		end
	end

	assign o_vram_pb = '{request: pb_request, rw: 1'b0, address: pb_address, wdata: 32'h0};

endmodule

//--- rtl/pixel_lookup.sv
`timescale 1ns/1ps

module pixel_lookup (
	input  logic                 i_clock,
	input  logic                 i_rst_n,

	input  vmode_pkg::video_in_t i_video,

	// Line buffer read port
	output logic [7:0]           o_line_rd_addr,
	input  logic [31:0]          i_line_rd_data,

	// Palette read port
	output logic [7:0]           o_pal_rd_addr,
	input  logic [23:0]          i_pal_rd_data,

	output logic [31:0]          o_video_rdata
);

	import vmode_pkg::*;

	logic [1:0] sel_d1;
	logic req_d1;
	logic req_d2;

	// Stage 1, word of four pixels
	assign o_line_rd_addr = i_video.pos_x[9:2];

	always_ff @(posedge i_clock) begin
		sel_d1 <= i_video.pos_x[1:0];
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			req_d1 <= 1'b0;
			req_d2 <= 1'b0;
		end else begin
			req_d1 <= i_video.request;
			req_d2 <= req_d1;
		end
	end

	// Stage 2, byte 0 is the leftmost pixel
	assign o_pal_rd_addr = i_line_rd_data[{sel_d1, 3'b000} +: 8];

	assign o_video_rdata = req_d2 ? {8'h00, i_pal_rd_data} : 32'h0;

endmodule

//--- rtl/vmode_chunky.sv
`timescale 1ns/1ps

module vmode_chunky #(
	parameter int PPITCH = 320
) (
	input  logic                 i_clock,
	input  logic                 i_rst_n,

	// CPU
	input  logic                 i_cpu_request,
	input  vmode_pkg::cpu_req_t  i_cpu,
	output logic [31:0]          o_cpu_rdata,
	output logic                 o_cpu_ready,

	// Video
	input  vmode_pkg::video_in_t i_video,
	output logic [31:0]          o_video_rdata,

	// Video memory
	output vmode_pkg::mem_req_t  o_vram_pa,
	input  vmode_pkg::mem_rsp_t  i_vram_pa,
	output vmode_pkg::mem_req_t  o_vram_pb,
	input  vmode_pkg::mem_rsp_t  i_vram_pb
);

	localparam int LINE_WORDS = PPITCH / 4;
	localparam int LINE_AW = $clog2(LINE_WORDS);

	logic pal_wr_en;
	logic [7:0] pal_wr_addr;
	logic [23:0] pal_wr_data;
	logic [7:0] pal_rd_addr;
	logic [23:0] pal_rd_data;
	logic [31:0] vram_offset;
	logic line_wr_en;
	logic [LINE_AW-1:0] line_wr_addr;
	logic [31:0] line_wr_data;
	logic [7:0] line_rd_addr;
	logic [31:0] line_rd_data;

	cpu_port_decoder i_cpu_port_decoder (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_cpu_request (i_cpu_request),
		.i_cpu         (i_cpu),
		.o_cpu_rdata   (o_cpu_rdata),
		.o_cpu_ready   (o_cpu_ready),
		.o_vram_pa     (o_vram_pa),
		.i_vram_pa     (i_vram_pa),
		.o_pal_wr_en   (pal_wr_en),
		.o_pal_wr_addr (pal_wr_addr),
		.o_pal_wr_data (pal_wr_data),
		.o_vram_offset (vram_offset)
	);

	line_fetcher #(
		.PPITCH (PPITCH)
	) i_line_fetcher (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_video        (i_video),
		.i_vram_offset  (vram_offset),
		.o_vram_pb      (o_vram_pb),
		.i_vram_pb      (i_vram_pb),
		.o_line_wr_en   (line_wr_en),
		.o_line_wr_addr (line_wr_addr),
		.o_line_wr_data (line_wr_data)
	);

	// One scanline of packed pixels
	dual_port_ram #(
		.WIDTH (32),
		.SIZE  (LINE_WORDS)
	) line_buffer (
		.i_clock   (i_clock),
		.i_wr_en   (line_wr_en),
		.i_wr_addr (line_wr_addr),
		.i_wr_data (line_wr_data),
		.i_rd_addr (line_rd_addr[LINE_AW-1:0]),
		.o_rd_data (line_rd_data)
	);

	dual_port_ram #(
		.WIDTH (24),
		.SIZE  (256)
	) palette (
		.i_clock   (i_clock),
		.i_wr_en   (pal_wr_en),
		.i_wr_addr (pal_wr_addr),
		.i_wr_data (pal_wr_data),
		.i_rd_addr (pal_rd_addr),
		.o_rd_data (pal_rd_data)
	);

	pixel_lookup i_pixel_lookup (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_video        (i_video),
		.o_line_rd_addr (line_rd_addr),
		.i_line_rd_data (line_rd_data),
		.o_pal_rd_addr  (pal_rd_addr),
		.i_pal_rd_data  (pal_rd_data),
		.o_video_rdata  (o_video_rdata)
	);

endmodule

//--- rtl/vmode_pkg.sv
package vmode_pkg;

	// ======================================================================
	// Address map
	// ======================================================================

	// Below this is video memory
	localparam logic [31:0] PALETTE_BASE = 32'h0080_0000;
	// Palette entries up to here, control registers above
	localparam logic [31:0] CTRL_BASE = 32'h0081_0000;

	// Control register offsets, address bits [3:0]
	localparam logic [3:0] REG_VRAM_OFFSET = 4'h0;
	localparam logic [3:0] REG_CPU_OFFSET = 4'h4;

	// ======================================================================
	// Bus structs
	// ======================================================================

	typedef struct packed {
		logic rw;
		logic [31:0] address;
		logic [31:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic request;
		logic rw;
		logic [31:0] address;
		logic [31:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic ready;
	} mem_rsp_t;

	// Timing comes from an external video timing generator
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic request;
		logic [9:0] pos_x;
		logic [9:0] pos_y;
	} video_in_t;

	typedef enum logic [1:0] {
		REGION_VRAM,
		REGION_PALETTE,
		REGION_CTRL
	} cpu_region_t;

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_WAIT_READY,
		FETCH_WAIT_RELEASE
	} fetch_state_t;

endpackage

//--- sim/tb_vmode_chunky.sv
`timescale 1ns/1ps

module tb_vmode_chunky;

	import vmode_pkg::*;

	localparam int PPITCH = 32;
	localparam int TIMEOUT = 200;

	logic clock;
	logic rst_n;
	logic cpu_request;
	cpu_req_t cpu;
	logic [31:0] cpu_rdata;
	logic cpu_ready;
	video_in_t video;
	logic [31:0] video_rdata;
	mem_req_t vram_pa_req;
	mem_rsp_t vram_pa_rsp;
	mem_req_t vram_pb_req;
	mem_rsp_t vram_pb_rsp;

	logic [31:0] shadow_mem [4096];
	logic [23:0] shadow_pal [256];
	logic [31:0] rng_state = 32'hadad_f5e9;
	logic [31:0] ref_offset = 32'h0;
	int ref_y = 0;
	logic [31:0] fetch_base = 32'h0;
	int pb_words = 0;
	int error_count = 0;
	int check_count = 0;
	int test_errors = 0;
	logic check_en = 1'b0;
	// Expected pixel pipe, bit 32 marks an entry to compare
	logic [32:0] stage1 = '0;
	logic [32:0] stage2 = '0;

	vmode_chunky #(
		.PPITCH (PPITCH)
	) i_vmode_chunky (
		.i_clock       (clock),
		.i_rst_n       (rst_n),
		.i_cpu_request (cpu_request),
		.i_cpu         (cpu),
		.o_cpu_rdata   (cpu_rdata),
		.o_cpu_ready   (cpu_ready),
		.i_video       (video),
		.o_video_rdata (video_rdata),
		.o_vram_pa     (vram_pa_req),
		.i_vram_pa     (vram_pa_rsp),
		.o_vram_pb     (vram_pb_req),
		.i_vram_pb     (vram_pb_rsp)
	);

	vram_model #(
		.WORDS (4096)
	) i_vram_model (
		.i_clock (clock),
		.i_pa    (vram_pa_req),
		.o_pa    (vram_pa_rsp),
		.i_pb    (vram_pb_req),
		.o_pb    (vram_pb_rsp)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#2 clock = ~clock;
		end
	end

	// ====================================================================
	// Reference model and checks
	// ====================================================================

	function automatic logic [31:0] random_word();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic int word_index(input logic [31:0] address);
		return int'(address[13:2]);
	endfunction

	function automatic logic [31:0] expected_pixel(input logic [31:0] offset, input int y,
			input int x);
		logic [31:0] word;
		logic [7:0] index;
		word = shadow_mem[word_index(offset + 32'(y * PPITCH) + 32'((x / 4) * 4))];
		index = word[(x % 4) * 8 +: 8];
		return {8'h00, shadow_pal[index]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, expected);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout: no %s within %0d cycles", what, TIMEOUT);
		$display("Checks: %0d, errors: %0d", check_count, error_count + 1);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	task automatic report_test(input string name);
		$display("Test %s finished with %0d errors", name, error_count - test_errors);
		test_errors = error_count;
	endtask

	// Output for the pixel presented at one edge is valid after the second edge
	always @(negedge clock) begin
		if (stage2[32]) begin
			check_value("o_video_rdata", video_rdata, stage2[31:0]);
		end
		stage2 = stage1;
		stage1[32] = check_en;
		stage1[31:0] = video.request ? expected_pixel(ref_offset, ref_y, int'(video.pos_x)) : 32'h0;
	end

	// Fetch reads walk the line word by word
	always @(negedge clock) begin
		if (vram_pb_rsp.ready) begin
			check_value("o_vram_pb.address", vram_pb_req.address, fetch_base + 32'(pb_words * 4));
			pb_words++;
		end
	end

	// ====================================================================
	// Stimulus
	// ====================================================================

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) begin
			next_cycle();
		end
	endtask

	task automatic cpu_access(input logic rw, input logic [31:0] address,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int cycles;
		cpu_request = 1'b1;
		cpu = '{rw: rw, address: address, wdata: wdata};
		cycles = 0;
		while (!cpu_ready) begin
			next_cycle();
			cycles++;
			if (cycles > TIMEOUT) begin
				stop_on_timeout("CPU ready");
			end
		end
		rdata = cpu_rdata;
		cpu_request = 1'b0;
		next_cycle();
	endtask

	task automatic load_frame(input logic [31:0] offset, input int lines);
		logic [31:0] data;
		for (int i = 0; i < lines * PPITCH / 4; i++) begin
			data = random_word();
			shadow_mem[word_index(offset + 32'(i * 4))] = data;
			i_vram_model.preload(word_index(offset + 32'(i * 4)), data);
		end
	endtask

	task automatic fetch_line(input logic [31:0] offset, input int y);
		int cycles;
		video.pos_y = 10'(y);
		fetch_base = offset + 32'(y * PPITCH);
		pb_words = 0;
		video.hsync = 1'b1;
		cycles = 0;
		while (pb_words < PPITCH / 4) begin
			next_cycle();
			cycles++;
			if (cycles > TIMEOUT) begin
				stop_on_timeout("line fetch");
			end
		end
		video.hsync = 1'b0;
		// Last word lands in the line buffer two edges after its ready
		wait_cycles(4);
		check_value("o_vram_pb.request", vram_pb_req.request, 32'h0);
		check_value("fetched words", pb_words, PPITCH / 4);
		ref_offset = offset;
		ref_y = y;
	endtask

	task automatic sweep_line(input logic drop);
		logic [31:0] r;
		check_en = 1'b1;
		for (int x = 0; x < PPITCH; x++) begin
			r = random_word();
			video.pos_x = 10'(x);
			video.request = !(drop && r[17:16] == 2'b00);
			next_cycle();
		end
		video.request = 1'b0;
		check_en = 1'b0;
		wait_cycles(3);
	endtask

	// ====================================================================
	// Test sequence
	// ====================================================================

	initial begin
		logic [31:0] data;
		logic [31:0] rdata;
		logic [31:0] cpu_offset;
		logic [31:0] addr_list [16];
		rst_n = 1'b0;
		cpu_request = 1'b0;
		cpu = '0;
		video = '0;
		repeat (4) begin
			@(posedge clock);
		end
		#1;
		rst_n = 1'b1;

		repeat (8) begin
			next_cycle();
			check_value("o_cpu_ready", cpu_ready, 32'h0);
			check_value("o_vram_pa.request", vram_pa_req.request, 32'h0);
			check_value("o_vram_pb.request", vram_pb_req.request, 32'h0);
		end
		report_test("1 reset idle");

		cpu_offset = 32'h0000_1000;
		cpu_access(1'b1, CTRL_BASE + 32'h4, cpu_offset, rdata);
		for (int i = 0; i < 16; i++) begin
			data = random_word();
			addr_list[i] = {22'h0, data[23:16], 2'b00};
			data = random_word();
			cpu_access(1'b1, addr_list[i], data, rdata);
			shadow_mem[word_index(cpu_offset + addr_list[i])] = data;
			check_value("vram address", i_vram_model.last_pa_address, cpu_offset + addr_list[i]);
		end
		for (int i = 0; i < 16; i++) begin
			cpu_access(1'b0, addr_list[i], 32'h0, rdata);
			check_value("o_cpu_rdata", rdata, shadow_mem[word_index(cpu_offset + addr_list[i])]);
			check_value("vram address", i_vram_model.last_pa_address, cpu_offset + addr_list[i]);
		end
		report_test("2 CPU video memory");

		for (int i = 0; i < 256; i++) begin
			data = random_word();
			shadow_pal[i] = data[31:8];
			cpu_access(1'b1, PALETTE_BASE + 32'(i * 4), {8'h00, data[31:8]}, rdata);
		end
		cpu_access(1'b0, PALETTE_BASE + 32'h4, 32'h0, rdata);
		check_value("palette read", rdata, 32'h0);
		load_frame(32'h0000_2000, 16);
		cpu_access(1'b1, CTRL_BASE, 32'h0000_2000, rdata);
		fetch_line(32'h0000_2000, 5);
		sweep_line(1'b0);
		report_test("3 fetch and sweep");

		sweep_line(1'b1);
		report_test("4 gated requests");

		// New data on line 9, the shown line stays 5
		video.vsync = 1'b1;
		wait_cycles(4);
		video.pos_y = 10'd9;
		load_frame(32'h0000_2000 + 32'(9 * PPITCH), 1);
		pb_words = 0;
		video.hsync = 1'b1;
		wait_cycles(8);
		check_value("fetched words in vsync", pb_words, 32'h0);
		video.hsync = 1'b0;
		wait_cycles(4);
		video.vsync = 1'b0;
		wait_cycles(4);
		sweep_line(1'b0);
		report_test("5 hsync in vsync");

		load_frame(32'h0000_3000, 16);
		cpu_access(1'b1, CTRL_BASE, 32'h0000_3000, rdata);
		fetch_line(32'h0000_3000, 3);
		sweep_line(1'b0);
		report_test("6 new video base");

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- sim/vram_model.sv
`timescale 1ns/1ps

module vram_model #(
	parameter int WORDS = 4096
) (
	input  logic                i_clock,
	input  vmode_pkg::mem_req_t i_pa,
	output vmode_pkg::mem_rsp_t o_pa,
	input  vmode_pkg::mem_req_t i_pb,
	output vmode_pkg::mem_rsp_t o_pb
);

	localparam int AW = $clog2(WORDS);

	logic [31:0] mem [WORDS];
	logic [31:0] last_pa_address = 32'h0;
	logic [31:0] seed_a = 32'hadad_f5e9;
	logic [31:0] seed_b = 32'hadad_f5e9;
	// 0 idle, above 0 cycles left, -1 waiting for the request to drop
	int wait_a = 0;
	int wait_b = 0;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic preload(input int word_addr, input logic [31:0] data);
		mem[word_addr] = data;
	endtask

	initial begin
		o_pa = '0;
		o_pb = '0;
	end

	always @(posedge i_clock) begin
		o_pa.ready <= 1'b0;
		if (wait_a == 0 && i_pa.request) begin
			seed_a = lcg_next(seed_a);
			wait_a = int'(seed_a[17:16]) + 1;
			last_pa_address <= i_pa.address;
		end else if (wait_a > 1) begin
			wait_a = wait_a - 1;
		end else if (wait_a == 1) begin
			if (i_pa.rw) begin
				mem[i_pa.address[AW+1:2]] = i_pa.wdata;
			end
			o_pa.rdata <= mem[i_pa.address[AW+1:2]];
			o_pa.ready <= 1'b1;
			wait_a = -1;
		end else if (wait_a < 0 && !i_pa.request) begin
			wait_a = 0;
		end
	end

	always @(posedge i_clock) begin
		o_pb.ready <= 1'b0;
		if (wait_b == 0 && i_pb.request) begin
			seed_b = lcg_next(seed_b);
			wait_b = int'(seed_b[17:16]) + 1;
		end else if (wait_b > 1) begin
			wait_b = wait_b - 1;
		end else if (wait_b == 1) begin
			if (i_pb.rw) begin
				mem[i_pb.address[AW+1:2]] = i_pb.wdata;
			end
			o_pb.rdata <= mem[i_pb.address[AW+1:2]];
			o_pb.ready <= 1'b1;
			wait_b = -1;
		end else if (wait_b < 0 && !i_pb.request) begin
			wait_b = 0;
		end
	end

endmodule
